// ==== project.f ====
+incdir+hw
hw/ss_bridge_pkg.sv
hw/ss_bus_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/ss_frame_ctrl.sv
hw/reg_target.sv
hw/ss_bridge_top.sv
bench/ss_bridge_properties.sv
bench/ss_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: ss_bridge

sources:
  - include_dirs:
      - hw
    files:
      - hw/ss_bridge_pkg.sv
      - hw/ss_bus_if.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/ss_frame_ctrl.sv
      - hw/reg_target.sv
      - hw/ss_bridge_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/ss_bridge_properties.sv
      - bench/ss_bridge_tb.sv

// ==== bench/ss_bridge_tb.sv ====
`timescale 1ns/1ps

`include "ss_bridge_defs.svh"

module ss_bridge_tb;
  import ss_bridge_pkg::*;

  localparam int BIT_CLKS   = `SS_BIT_CLKS;
  localparam int BYTE_CLKS  = 10 * BIT_CLKS;             // start + 8 data + stop
  localparam int N_RAND     = 30;                        // random frames
  localparam int N_FRAMES   = N_RAND + 7;                // plus directed ones
  localparam int MAX_CYCLES = (N_FRAMES + 4) * 10 * BYTE_CLKS;  // 10 bytes per frame worst case

  logic   clk, rst, rxd;
  logic   txd, trig, err;
  integer seed;
  byte_t  model_regs [`SS_NUM_REGS];  // expected register contents
  int     trig_exp;                   // writes made to the trigger register
  int     trig_seen;                  // trig cycles seen on the pin
  byte_t  reply_q [$];                // bytes caught on txd

  ss_bridge_top UUT (.clk(clk), .rst(rst), .rxd(rxd), .txd(txd), .trig(trig), .err(err));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  always @(posedge clk) begin
    if (rst) trig_seen <= 0;
    else if (trig) trig_seen <= trig_seen + 1;  // one count per high cycle
  end

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t got);
    if (exp !== got) begin
      $display("FAIL %s exp %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_trig(input int exp, input int got);
    if (exp !== got) begin
      $display("FAIL trig exp %h got %h", exp, got);
      abort_run();
    end
  endtask

  task automatic check_err(input logic exp, input logic got);
    if (exp !== got) begin
      $display("FAIL err exp %h got %h", exp, got);
      abort_run();
    end
  endtask

  // reference model of the register block
  function automatic void model_write(input reg_addr_t a, input byte_t d);
    if (a == `SS_REG_TRIG) trig_exp++;
    if (a != `SS_REG_TCNT) model_regs[a] = d;  // count reg is read-only
  endfunction

  function automatic byte_t model_read(input reg_addr_t a);
    if (a == `SS_REG_TCNT) return byte_t'(trig_exp);  // count mod 256
    return model_regs[a];
  endfunction

  // host side of the line, called on a rising edge
  task automatic drive_bit(input logic v);
    rxd <= v;
    repeat (BIT_CLKS) @(posedge clk);
  endtask

  task automatic send_byte(input byte_t b, input logic stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(b[i]);  // lsb first
    drive_bit(stop);
    if (!stop) drive_bit(1'b1);  // back to idle so the next start edge is seen
  endtask

  // txd monitor, samples each bit near its middle
  initial begin : tx_monitor
    byte_t b;
    logic  prev;
    prev = 1'b1;
    forever begin
      @(posedge clk);
      if (!rst && prev && !txd) begin
        repeat (BIT_CLKS / 2) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CLKS) @(posedge clk);
          b[i] = txd;
        end
        repeat (BIT_CLKS) @(posedge clk);
        if (txd !== 1'b1) begin
          $display("reply byte has a low stop bit");
          abort_run();
        end
        reply_q.push_back(b);
      end
      prev = txd;
    end
  end

  // each reply byte gets 2 byte times
  task automatic wait_reply(input int n);
    int waited;
    for (int k = 1; k <= n; k++) begin
      waited = 0;
      while (reply_q.size() < k) begin
        @(posedge clk);
        waited++;
        if (waited > 2 * BYTE_CLKS) begin
          $display("reply byte %0d of %0d never arrived on txd", k, n);
          abort_run();
        end
      end
    end
  endtask

  task automatic frame_gap();
    repeat (2 * BIT_CLKS) @(posedge clk);
    if (reply_q.size() != 0) begin
      $display("unexpected extra reply byte on txd");
      abort_run();
    end
  endtask

  task automatic run_write(input reg_addr_t start, input int len);
    rx_word_u  hw;
    reg_addr_t a;
    byte_t     d;
    hw.hdr.write  = 1'b1;
    hw.hdr.len_m1 = 3'(len - 1);
    hw.hdr.start  = start;
    send_byte(hw.raw, 1'b1);
    a = start;
    for (int i = 0; i < len; i++) begin
      d = byte_t'($random(seed));
      send_byte(d, 1'b1);
      model_write(a, d);
      a = a + 1'b1;  // wraps mod 16
    end
    wait_reply(1);
    check_byte("ack", `SS_ACK_CODE, reply_q.pop_front());
    check_trig(trig_exp, trig_seen);  // pulses long done by the ack
    frame_gap();
  endtask

  task automatic run_read(input reg_addr_t start, input int len);
    rx_word_u  hw;
    reg_addr_t a;
    hw.hdr.write  = 1'b0;
    hw.hdr.len_m1 = 3'(len - 1);
    hw.hdr.start  = start;
    send_byte(hw.raw, 1'b1);
    wait_reply(len);
    a = start;
    for (int i = 0; i < len; i++) begin
      check_byte("rdata", model_read(a), reply_q.pop_front());
      a = a + 1'b1;
    end
    frame_gap();
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        abort_run();
      end
    end
  end

  initial begin : main
    rx_word_u    hw;
    logic [31:0] rnd;
    rst      = 1'b1;
    rxd      = 1'b1;  // line idle
    seed     = 32'h67b70742;
    trig_exp = 0;
    for (int i = 0; i < `SS_NUM_REGS; i++) model_regs[i] = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    check_err(1'b0, err);
    check_trig(0, trig_seen);

    run_read(4'd0, 8);   // reset values, count reads 0
    run_read(4'd8, 8);
    run_write(4'd13, 8); // crosses 14, 15 and wraps to 0
    run_read(4'd12, 8);

    for (int n = 0; n < N_RAND; n++) begin
      rnd = $random(seed);
      if (rnd[0]) run_write(rnd[7:4], int'(rnd[3:1]) + 1);
      else run_read(rnd[7:4], int'(rnd[3:1]) + 1);
    end

    // bad stop bit inside a write frame, frame is dropped without ack
    hw.hdr.write  = 1'b1;
    hw.hdr.len_m1 = 3'd3;
    hw.hdr.start  = 4'd3;
    send_byte(hw.raw, 1'b1);
    send_byte(byte_t'($random(seed)), 1'b0);
    frame_gap();
    check_err(1'b1, err);
    run_read(4'd0, 8);   // bridge still answers
    run_read(4'd8, 8);

    check_err(1'b1, err);  // sticky to the end
    check_trig(trig_exp, trig_seen);
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== bench/ss_bridge_properties.sv ====
`timescale 1ns/1ps

module ss_bridge_properties (
  input logic clk,
  input logic rst,
  input logic rx_valid,
  input logic wr,
  input logic rd,
  input logic tx_start,
  input logic tx_busy
);
  logic rx_seen;  // set by the first received byte after reset

  always_ff @(posedge clk) begin
    if (rst) rx_seen <= 1'b0;
    else if (rx_valid) rx_seen <= 1'b1;
  end

  // bus strobes are exclusive
  a_wr_rd_excl: assert property (@(posedge clk) disable iff (rst) !(wr && rd))
    else $error("wr and rd high in the same cycle");

  a_tx_start_idle: assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
    else $error("tx_start while transmitter busy");

  // nothing moves before the host has sent a byte
  a_quiet_after_rst: assert property (@(posedge clk) disable iff (rst)
      !rx_seen |-> !(wr || rd || tx_start))
    else $error("bus or tx activity before first received byte");

endmodule

bind ss_frame_ctrl ss_bridge_properties u_props (
  .clk      (clk),
  .rst      (rst),
  .rx_valid (rx_valid),
  .wr       (bus.wr),
  .rd       (bus.rd),
  .tx_start (tx_start),
  .tx_busy  (tx_busy)
);

// ==== hw/ss_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ss_bridge_top (
  input  logic  clk,
  input  logic  rst,
  input  logic  rxd,
  output logic  txd,
  output logic  trig,
  output logic  err
);
  import ss_bridge_pkg::*;

  byte_t rx_byte;
  byte_t tx_byte;
  logic  rx_valid, rx_err;
  logic  tx_start, tx_busy;

  ss_bus_if bus ();  // internal register bus

  uart_rx u_rx (
    .clk      (clk),
    .rst      (rst),
    .rxd      (rxd),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_err   (rx_err)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst      (rst),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .txd      (txd),
    .tx_busy  (tx_busy)
  );

  ss_frame_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_err   (rx_err),
    .tx_busy  (tx_busy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .err      (err),
    .bus      (bus.master)
  );

  reg_target u_regs (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus.target),
    .trig     (trig)
  );

endmodule

`default_nettype wire

// ==== hw/reg_target.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ss_bridge_defs.svh"

module reg_target (
  input  logic      clk,
  input  logic      rst,
  ss_bus_if.target  bus,
  output logic      trig
);
  import ss_bridge_pkg::*;

  byte_t regs [`SS_NUM_REGS];  // slot 14 holds the trigger count
  logic  trig_hit;
  logic  tcnt_sel;

  assign trig_hit = bus.wr && (bus.addr == reg_addr_t'(`SS_REG_TRIG));
  assign tcnt_sel = (bus.addr == reg_addr_t'(`SS_REG_TCNT));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SS_NUM_REGS; i++) regs[i] <= '0;
      trig <= 1'b0;
    end else begin
      trig <= trig_hit;  // one cycle after the wr strobe
      if (trig_hit) regs[`SS_REG_TCNT] <= regs[`SS_REG_TCNT] + 1'b1;  // mod 256
      if (bus.wr && !tcnt_sel) regs[bus.addr] <= bus.wdata;  // count reg is read-only
    end
  end

  // registered read data
  always_ff @(posedge clk) begin
    if (bus.rd) bus.rdata <= regs[bus.addr];
  end

endmodule

`default_nettype wire

// ==== hw/ss_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ss_bridge_defs.svh"

module ss_frame_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  ss_bridge_pkg::byte_t  rx_byte,
  input  logic                  rx_valid,
  input  logic                  rx_err,
  input  logic                  tx_busy,
  output ss_bridge_pkg::byte_t  tx_byte,
  output logic                  tx_start,
  output logic                  err,
  ss_bus_if.master              bus
);
  import ss_bridge_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,      // reply still on the line, incoming bytes dropped
    ST_HEADER,    // waiting for a header byte
    ST_WR_DATA,
    ST_ACK,
    ST_RD_ISSUE,
    ST_RD_SEND
  } state_t;

  state_t     state;
  rx_word_u   rx_word;
  reg_addr_t  addr_q;   // current register, wraps at 16
  logic [2:0] cnt_q;    // bytes left after the current one
  logic       wr_q;
  byte_t      wdata_q;

  assign rx_word.raw = rx_byte;

  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.wr    = wr_q;
  // read strobe once the transmitter is free, rdata lands in ST_RD_SEND
  assign bus.rd    = (state == ST_RD_ISSUE) && !tx_busy;

  // rd already waited on tx_busy, so ST_RD_SEND can start right away
  assign tx_start = (state == ST_RD_SEND) || ((state == ST_ACK) && !tx_busy);
  assign tx_byte  = (state == ST_ACK) ? byte_t'(`SS_ACK_CODE) : bus.rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_HEADER;
      addr_q <= '0;
      cnt_q  <= '0;
      wr_q   <= 1'b0;
      err    <= 1'b0;
    end else begin
      wr_q <= 1'b0;
      if (wr_q) addr_q <= addr_q + 1'b1;  // step past the register just written

      if (rx_err) begin
        err   <= 1'b1;        // sticky until reset
        state <= ST_HEADER;   // frame in progress is dropped
      end else begin
        case (state)
          ST_IDLE: if (!tx_busy) state <= ST_HEADER;
          ST_HEADER: begin
            if (rx_valid) begin
              addr_q <= rx_word.hdr.start;
              cnt_q  <= rx_word.hdr.len_m1;
              state  <= rx_word.hdr.write ? ST_WR_DATA : ST_RD_ISSUE;
            end
          end
          ST_WR_DATA: begin
            if (rx_valid) begin
              wr_q    <= 1'b1;         // bus write one cycle after rx_valid
              wdata_q <= rx_word.raw;
              if (cnt_q == 3'd0) state <= ST_ACK;
              else cnt_q <= cnt_q - 1'b1;
            end
          end
          ST_ACK: if (!tx_busy) state <= ST_IDLE;  // ack byte goes out here
          ST_RD_ISSUE: if (!tx_busy) state <= ST_RD_SEND;
          ST_RD_SEND: begin
            if (cnt_q == 3'd0) state <= ST_IDLE;  // last byte of the burst
            else begin
              cnt_q  <= cnt_q - 1'b1;
              addr_q <= addr_q + 1'b1;            // wraps mod 16
              state  <= ST_RD_ISSUE;
            end
          end
          default: state <= ST_HEADER;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ss_bridge_defs.svh"

module uart_tx (
  input  logic                  clk,
  input  logic                  rst,
  input  ss_bridge_pkg::byte_t  tx_byte,
  input  logic                  tx_start,
  output logic                  txd,
  output logic                  tx_busy
);
  import ss_bridge_pkg::*;

  localparam int BIT_CLKS = `SS_BIT_CLKS;
  localparam int CNT_W    = $clog2(BIT_CLKS);

  logic [8:0]       shreg;   // data then stop bit, start bit goes out directly
  logic [CNT_W-1:0] cnt;
  logic [3:0]       bit_cnt; // 0 = start bit .. 9 = stop bit

  always_ff @(posedge clk) begin
    if (rst) begin
      txd     <= 1'b1;  // line idles high
      tx_busy <= 1'b0;
      cnt     <= '0;
      bit_cnt <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        txd     <= 1'b0;             // start bit in the next cycle
        shreg   <= {1'b1, tx_byte};
        tx_busy <= 1'b1;
        cnt     <= '0;
        bit_cnt <= '0;
      end
    end else if (cnt == CNT_W'(BIT_CLKS - 1)) begin
      cnt <= '0;
      if (bit_cnt == 4'd9) tx_busy <= 1'b0;  // stop bit done, 10 bit times total
      else begin
        txd     <= shreg[0];
        shreg   <= {1'b1, shreg[8:1]};
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ss_bridge_defs.svh"

module uart_rx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rxd,
  output ss_bridge_pkg::byte_t  rx_byte,
  output logic                  rx_valid,
  output logic                  rx_err
);
  import ss_bridge_pkg::*;

  localparam int BIT_CLKS = `SS_BIT_CLKS;
  localparam int CNT_W    = $clog2(BIT_CLKS);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        state;
  logic             rxd_m, rxd_s, rxd_d;  // sync pair plus edge delay
  logic [CNT_W-1:0] cnt;                  // clocks inside current bit
  logic [2:0]       bit_idx;
  byte_t            shreg;
  logic             start_edge;

  // falling edge only, so a line held low after a bad stop bit is not a new start
  assign start_edge = rxd_d & ~rxd_s;
  assign rx_byte    = shreg;

  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_m    <= 1'b1;
      rxd_s    <= 1'b1;
      rxd_d    <= 1'b1;
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      rxd_m    <= rxd;
      rxd_s    <= rxd_m;
      rxd_d    <= rxd_s;
      rx_valid <= 1'b0;  // strobes by default
      rx_err   <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (start_edge) state <= RX_START;
        end
        RX_START: begin
          if (cnt == CNT_W'(BIT_CLKS / 2 - 1)) begin  // middle of start bit
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_s ? RX_IDLE : RX_DATA;      // high again -> glitch
          end else cnt <= cnt + 1'b1;
        end
        RX_DATA: begin
          if (cnt == CNT_W'(BIT_CLKS - 1)) begin
            cnt     <= '0;
            shreg   <= {rxd_s, shreg[7:1]};  // lsb first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else cnt <= cnt + 1'b1;
        end
        RX_STOP: begin
          if (cnt == CNT_W'(BIT_CLKS - 1)) begin
            rx_valid <= rxd_s;
            rx_err   <= ~rxd_s;  // framing error replaces valid
            state    <= RX_IDLE;
          end else cnt <= cnt + 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/ss_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ss_bus_if;
  import ss_bridge_pkg::*;

  reg_addr_t addr;   // register select
  byte_t     wdata;  // write data, valid with wr
  byte_t     rdata;  // read data, one cycle after rd
  logic      wr;     // single-cycle write strobe
  logic      rd;     // single-cycle read strobe

  // frame controller side
  modport master (output addr, wdata, wr, rd, input rdata);

  // register block side
  modport target (input addr, wdata, wr, rd, output rdata);

endinterface

`default_nettype wire

// ==== hw/ss_bridge_pkg.sv ====
package ss_bridge_pkg;

  // register address on the internal bus, 16 regs
  typedef logic [3:0] reg_addr_t;

  typedef logic [7:0] byte_t;  // one data byte

  // header byte of every frame, msb first
  typedef struct packed {
    logic       write;   // 1 = write frame, 0 = read
    logic [2:0] len_m1;  // burst length minus one
    reg_addr_t  start;   // first register of the burst
  } frame_hdr_t;

  // received byte seen either as header or as plain data
  typedef union packed {
    byte_t      raw;
    frame_hdr_t hdr;
  } rx_word_u;

endpackage

// ==== hw/ss_bridge_defs.svh ====
`ifndef SS_BRIDGE_DEFS_SVH
`define SS_BRIDGE_DEFS_SVH

// clocks per uart bit, 16 for sim (32 or 64 also fine)
`define SS_BIT_CLKS 16

// register address space of the bus
`define SS_NUM_REGS 16

// reply byte sent once a write frame is done
`define SS_ACK_CODE 8'hA5

// special registers
`define SS_REG_TRIG 4'd15  // write pulses trig
`define SS_REG_TCNT 4'd14  // read-only count of trig writes

`endif
